/* src/minimac_pkg.sv */
// minimac shared definitions
// Vector types for the rx datapath, the slot state and the CSR map

`default_nettype none

package minimac_pkg;

	typedef logic [13:0] csr_adr_t;    // CSR address, bank select in 13:10
	typedef logic [31:0] csr_data_t;
	typedef logic [47:0] mac_addr_t;   // Station address, MSB goes first on the wire
	typedef logic [29:0] word_adr_t;   // Word address into system memory
	typedef logic [10:0] byte_count_t; // Up to 2047 bytes per frame
	typedef logic [3:0]  nibble_t;     // One MII nibble
	typedef logic [7:0]  byte_t;
	typedef logic [31:0] word_t;       // One Wishbone data word

	// Receive slot
	typedef enum logic [1:0] {
		RX_EMPTY   = 2'd0, // No buffer given
		RX_LOADED  = 2'd1, // Armed, waiting for a frame
		RX_PENDING = 2'd2  // Frame stored, CPU must clear
	} rx_state_e;

	// CSR register indices, csr_adr_i[2:0]
	localparam logic [2:0] REG_SETUP    = 3'd0;
	localparam logic [2:0] REG_MAC_HI   = 3'd1;
	localparam logic [2:0] REG_MAC_LO   = 3'd2;
	localparam logic [2:0] REG_RX_STATE = 3'd3;
	localparam logic [2:0] REG_RX_ADR   = 3'd4;
	localparam logic [2:0] REG_RX_COUNT = 3'd5;

endpackage

`default_nettype wire

/* src/minimac_ctlif.sv */
// minimac control interface
// CSR bank, receive slot FSM, frame byte counter and rx interrupt

`timescale 1ns/10ps
`default_nettype none

module minimac_ctlif import minimac_pkg::*; #(
	parameter logic [3:0] csr_addr = 4'h0
) (
	input  wire        sys_clk_i,
	input  wire        reset_i,

	input  csr_adr_t   csr_adr_i,
	input  wire        csr_we_i,
	input  csr_data_t  csr_dat_i,
	output csr_data_t  csr_dat_o,

	input  wire        byte_valid_i,
	input  wire        sof_i,
	input  wire        eof_i,
	input  wire        err_i,
	input  wire        match_i,
	input  wire        endframe_i,
	input  wire        overflow_i,

	output logic       irq_rx_o,
	output logic       promisc_o,
	output mac_addr_t  macaddr_o,
	output logic       rx_valid_o,
	output word_adr_t  rx_adr_o
);

	rx_state_e   state_q;
	byte_count_t count_q;      // Running count of the current frame
	byte_count_t rx_count_q;   // Count of the last accepted frame
	logic        accept_q;     // Decision taken at eof
	logic        eof_seen_q;   // Eof seen, endframe still due
	logic        csr_sel;

	assign csr_sel = (csr_adr_i[13:10] == csr_addr);

	assign rx_valid_o = (state_q == RX_LOADED);
	assign irq_rx_o   = (state_q == RX_PENDING); // Held until the CPU empties the slot

	// Registers and slot FSM
	always_ff @(posedge sys_clk_i) begin
		if (reset_i) begin
			state_q    <= RX_EMPTY;
			promisc_o  <= 1'b0;
			macaddr_o  <= '0;
			rx_adr_o   <= '0;
			rx_count_q <= '0;
			accept_q   <= 1'b0;
			eof_seen_q <= 1'b0;
		end else begin
			if (eof_i) begin
				accept_q   <= match_i & ~err_i; // Good frame to us
				eof_seen_q <= 1'b1;
			end
			if (endframe_i && eof_seen_q) begin
				eof_seen_q <= 1'b0;
				// Overflow is only known once the last word has gone out
				if (state_q == RX_LOADED && accept_q && !overflow_i) begin
					state_q    <= RX_PENDING;
					rx_count_q <= count_q;
				end
			end
			if (csr_sel && csr_we_i) begin
				case (csr_adr_i[2:0])
					REG_SETUP:  promisc_o <= csr_dat_i[0];
					REG_MAC_HI: macaddr_o[47:32] <= csr_dat_i[15:0];
					REG_MAC_LO: macaddr_o[31:0] <= csr_dat_i;
					REG_RX_STATE: begin
						if (csr_dat_i[1:0] == 2'd1)
							state_q <= RX_LOADED; // Arm
						else if (csr_dat_i[1:0] == 2'd0)
							state_q <= RX_EMPTY;  // Release after reading the frame
					end
					REG_RX_ADR: rx_adr_o <= csr_dat_i[29:0];
					default: ;
				endcase
			end
		end
	end

	// Byte counter, first byte comes with sof
	always_ff @(posedge sys_clk_i) begin
		if (reset_i)
			count_q <= '0;
		else if (byte_valid_i)
			count_q <= sof_i ? byte_count_t'(1) : count_q + 1'b1;
	end

	// Registered read port
	always_ff @(posedge sys_clk_i) begin
		if (reset_i) begin
			csr_dat_o <= '0;
		end else begin
			csr_dat_o <= '0;
			if (csr_sel) begin
				case (csr_adr_i[2:0])
					REG_SETUP:    csr_dat_o <= {31'd0, promisc_o};
					REG_MAC_HI:   csr_dat_o <= {16'd0, macaddr_o[47:32]};
					REG_MAC_LO:   csr_dat_o <= macaddr_o[31:0];
					REG_RX_STATE: csr_dat_o <= {30'd0, state_q};
					REG_RX_ADR:   csr_dat_o <= {2'd0, rx_adr_o};
					REG_RX_COUNT: csr_dat_o <= {21'd0, rx_count_q};
					default:      csr_dat_o <= '0;
				endcase
			end
		end
	end

	// The dma may only finish a frame that the assembler has closed
	a_endframe_after_eof: assert property (@(posedge sys_clk_i) disable iff (reset_i)
		endframe_i |-> eof_seen_q);

endmodule

`default_nettype wire

/* src/minimac_rx_assemble.sv */
// minimac rx byte assembler
// Hunts for the SFD, pairs MII nibbles into bytes, flags sof/eof and errors

`timescale 1ns/10ps
`default_nettype none

module minimac_rx_assemble import minimac_pkg::*; (
	input  wire        sys_clk_i,
	input  wire        reset_i,
	input  nibble_t    phy_rx_data_i,
	input  wire        phy_dv_i,
	input  wire        phy_rx_er_i,
	output byte_t      byte_o,
	output logic       byte_valid_o,
	output logic       sof_o,
	output logic       eof_o,
	output logic       err_o
);

	typedef enum logic {HUNT, DATA} asm_state_e;

	asm_state_e state_q;
	nibble_t    data_q;   // PHY inputs sampled
	logic       dv_q;
	logic       er_q;
	nibble_t    low_q;    // Low nibble waiting for its partner
	logic       half_q;   // Low nibble held
	logic       first_q;  // Next byte is the first of the frame
	logic       err_acc_q;

	always_ff @(posedge sys_clk_i) begin
		data_q <= phy_rx_data_i;
		if (reset_i) begin
			dv_q <= 1'b0;
			er_q <= 1'b0;
		end else begin
			dv_q <= phy_dv_i;
			er_q <= phy_rx_er_i;
		end
	end

	always_ff @(posedge sys_clk_i) begin
		if (reset_i) begin
			state_q <= HUNT;
			half_q <= 1'b0;
			first_q <= 1'b0;
			err_acc_q <= 1'b0;
			byte_valid_o <= 1'b0;
			sof_o <= 1'b0;
			eof_o <= 1'b0;
			err_o <= 1'b0;
		end else begin
			byte_valid_o <= 1'b0;
			sof_o <= 1'b0;
			eof_o <= 1'b0;
			case (state_q)
				HUNT: begin
					// Preamble nibbles are 5, SFD nibble is D
					if (dv_q && data_q == 4'hd) begin
						state_q <= DATA;
						half_q <= 1'b0;
						first_q <= 1'b1;
						err_acc_q <= er_q;
					end
				end
				DATA: begin
					if (!dv_q) begin
						state_q <= HUNT;
						eof_o <= 1'b1;
						err_o <= err_acc_q | half_q; // Odd nibble count is an error too
					end else begin
						if (er_q)
							err_acc_q <= 1'b1;
						half_q <= ~half_q;
						if (half_q) begin
							byte_valid_o <= 1'b1;
							sof_o <= first_q;
							first_q <= 1'b0;
						end
					end
				end
				default: state_q <= HUNT;
			endcase
		end
	end

	// Byte payload, low nibble arrives first
	always_ff @(posedge sys_clk_i) begin
		if (state_q == DATA && dv_q) begin
			if (!half_q)
				low_q <= data_q;
			else
				byte_o <= {data_q, low_q};
		end
	end

endmodule

`default_nettype wire

/* src/minimac_rx_filter.sv */
// minimac rx address filter
// Matches the destination address against the station address or broadcast

`timescale 1ns/10ps
`default_nettype none

module minimac_rx_filter import minimac_pkg::*; (
	input  wire        sys_clk_i,
	input  wire        reset_i,
	input  byte_t      byte_i,
	input  wire        byte_valid_i,
	input  wire        sof_i,
	input  wire        eof_i,
	input  mac_addr_t  macaddr_i,
	input  wire        promisc_i,
	output logic       match_o
);

	logic [2:0] idx_q;    // Destination bytes seen so far
	logic [2:0] cur_idx;  // Index of the byte on byte_i
	logic       mac_ok_q;
	logic       bc_ok_q;
	byte_t      mac_byte;

	assign cur_idx = sof_i ? 3'd0 : idx_q;

	// Station address goes out MSB first
	assign mac_byte = macaddr_i[8*(3'd5 - cur_idx) +: 8];

	always_ff @(posedge sys_clk_i) begin
		if (reset_i) begin
			idx_q <= 3'd0;
			mac_ok_q <= 1'b0;
			bc_ok_q <= 1'b0;
		end else if (byte_valid_i && cur_idx < 3'd6) begin
			mac_ok_q <= (sof_i | mac_ok_q) & (byte_i == mac_byte);
			bc_ok_q <= (sof_i | bc_ok_q) & (byte_i == 8'hff);
			idx_q <= cur_idx + 3'd1;
		end
	end

	// Decision for the control module, qualified by eof
	// Short frames never reach idx 6
	assign match_o = eof_i & (promisc_i | ((idx_q == 3'd6) & (mac_ok_q | bc_ok_q)));

endmodule

`default_nettype wire

/* src/minimac_rx_pack.sv */
// minimac rx word packer
// Packs bytes big-endian into 32-bit words, pads and flushes the tail at eof

`timescale 1ns/10ps
`default_nettype none

module minimac_rx_pack import minimac_pkg::*; (
	input  wire   sys_clk_i,
	input  wire   reset_i,
	input  byte_t byte_i,
	input  wire   byte_valid_i,
	input  wire   sof_i,
	input  wire   eof_i,
	output word_t word_o,
	output logic  word_valid_o,
	output logic  last_o
);

	logic [1:0] lane_q;    // Bytes held in the shift register
	logic [1:0] cur_lane;
	word_t      shift_q;
	logic       flush_q;   // Padded tail word is on word_o

	assign cur_lane = sof_i ? 2'd0 : lane_q;

	always_ff @(posedge sys_clk_i) begin
		if (reset_i) begin
			lane_q <= 2'd0;
			word_valid_o <= 1'b0;
			flush_q <= 1'b0;
		end else begin
			word_valid_o <= 1'b0;
			flush_q <= 1'b0;
			if (byte_valid_i) begin
				lane_q <= cur_lane + 2'd1;
				if (cur_lane == 2'd3)
					word_valid_o <= 1'b1; // Full word
			end else if (eof_i && lane_q != 2'd0) begin
				word_valid_o <= 1'b1;
				flush_q <= 1'b1;
				lane_q <= 2'd0;
			end
		end
	end

	always_ff @(posedge sys_clk_i) begin
		if (byte_valid_i) begin
			shift_q <= {shift_q[23:0], byte_i};
			if (cur_lane == 2'd3)
				word_o <= {shift_q[23:0], byte_i};
		end else if (eof_i) begin
			// Left-align the remaining bytes, zero fill
			case (lane_q)
				2'd1:    word_o <= {shift_q[7:0], 24'd0};
				2'd2:    word_o <= {shift_q[15:0], 16'd0};
				default: word_o <= {shift_q[23:0], 8'd0};
			endcase
		end
	end

	// A full word meets eof when the frame ends on a word boundary
	assign last_o = flush_q | (word_valid_o & eof_i);

	a_word_spacing: assert property (@(posedge sys_clk_i) disable iff (reset_i)
		word_valid_o |=> !word_valid_o);

endmodule

`default_nettype wire

/* src/minimac_rx_dma.sv */
// minimac rx dma
// Word FIFO feeding a Wishbone classic write master into the rx buffer

`timescale 1ns/10ps
`default_nettype none

module minimac_rx_dma import minimac_pkg::*; #(
	parameter int fifo_depth = 4
) (
	input  wire        sys_clk_i,
	input  wire        reset_i,
	input  word_t      word_i,
	input  wire        word_valid_i,
	input  wire        last_i,
	input  wire        sof_i,
	input  wire        rx_valid_i,
	input  word_adr_t  rx_adr_i,
	input  wire        wbm_ack_i,
	output word_adr_t  wbm_adr_o,
	output word_t      wbm_dat_o,
	output logic [3:0] wbm_sel_o,
	output logic       wbm_we_o,
	output logic       wbm_cyc_o,
	output logic       wbm_stb_o,
	output logic       endframe_o,
	output logic       overflow_o
);

	localparam int aw = $clog2(fifo_depth);

	typedef enum logic {IDLE, BUS} bus_state_e;

	logic [32:0]  fifo_mem [fifo_depth]; // {last, word}
	logic [aw-1:0] wr_ptr_q;
	logic [aw-1:0] rd_ptr_q;
	logic [aw:0]   level_q;
	logic          push;
	logic          pop;
	bus_state_e    state_q;
	word_adr_t     offset_q;             // Words written in this frame
	logic          cur_last_q;

	assign push = word_valid_i & rx_valid_i & (level_q != fifo_depth);
	assign pop  = (state_q == IDLE) & (level_q != '0);

	assign wbm_sel_o = 4'hf;
	assign wbm_we_o  = 1'b1;              // Write-only master
	assign wbm_stb_o = wbm_cyc_o;

	always_ff @(posedge sys_clk_i) begin
		if (push)
			fifo_mem[wr_ptr_q] <= {last_i, word_i};
	end

	always_ff @(posedge sys_clk_i) begin
		if (reset_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			level_q <= '0;
			overflow_o <= 1'b0;
		end else begin
			if (push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			level_q <= level_q + push - pop;
			if (sof_i)
				overflow_o <= 1'b0;
			else if (word_valid_i && rx_valid_i && level_q == fifo_depth)
				overflow_o <= 1'b1; // Word lost, frame is spoiled
		end
	end

	// Wishbone write FSM
	always_ff @(posedge sys_clk_i) begin
		if (reset_i) begin
			state_q <= IDLE;
			wbm_cyc_o <= 1'b0;
			offset_q <= '0;
			endframe_o <= 1'b0;
			cur_last_q <= 1'b0;
		end else begin
			endframe_o <= 1'b0;
			if (sof_i)
				offset_q <= '0;
			case (state_q)
				IDLE: if (pop) begin
					wbm_cyc_o <= 1'b1;
					cur_last_q <= fifo_mem[rd_ptr_q][32];
					state_q <= BUS;
				end
				BUS: if (wbm_ack_i) begin
					wbm_cyc_o <= 1'b0;
					offset_q <= offset_q + 1'b1;
					endframe_o <= cur_last_q;
					state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Address and data stay put for the whole cycle
	always_ff @(posedge sys_clk_i) begin
		if (pop) begin
			wbm_dat_o <= fifo_mem[rd_ptr_q][31:0];
			wbm_adr_o <= rx_adr_i + offset_q;
		end
	end

	a_stb_until_ack: assert property (@(posedge sys_clk_i) disable iff (reset_i)
		wbm_stb_o && !wbm_ack_i |=> wbm_stb_o && $stable(wbm_adr_o) && $stable(wbm_dat_o));

endmodule

`default_nettype wire

/* src/minimac.sv */
// minimac receive MAC
// MII rx path into system memory over Wishbone, controlled through CSRs

`timescale 1ns/10ps
`default_nettype none

module minimac import minimac_pkg::*; #(
	parameter logic [3:0] csr_addr   = 4'h0,
	parameter int         fifo_depth = 4
) (
	input  wire        sys_clk_i,
	input  wire        reset_i,
	input  csr_adr_t   csr_adr_i,
	input  wire        csr_we_i,
	input  csr_data_t  csr_dat_i,
	output csr_data_t  csr_dat_o,
	output wire        irq_rx_o,
	output word_adr_t  wbm_adr_o,
	output word_t      wbm_dat_o,
	output wire [3:0]  wbm_sel_o,
	output wire        wbm_we_o,
	output wire        wbm_cyc_o,
	output wire        wbm_stb_o,
	input  wire        wbm_ack_i,
	input  nibble_t    phy_rx_data_i,
	input  wire        phy_dv_i,
	input  wire        phy_rx_er_i
);

	wire       promisc;
	mac_addr_t macaddr;
	wire       rx_valid;
	word_adr_t rx_adr;
	byte_t     rx_byte;   // Assembled byte stream
	wire       byte_valid;
	wire       sof;
	wire       eof;
	wire       err;
	wire       match;
	word_t     rx_word;   // Packed word stream
	wire       word_valid;
	wire       last;
	wire       endframe;
	wire       overflow;

	minimac_ctlif #(.csr_addr(csr_addr)) i_ctlif (
		.sys_clk_i(sys_clk_i), .reset_i(reset_i),
		.csr_adr_i(csr_adr_i), .csr_we_i(csr_we_i),
		.csr_dat_i(csr_dat_i), .csr_dat_o(csr_dat_o),
		.byte_valid_i(byte_valid), .sof_i(sof), .eof_i(eof), .err_i(err),
		.match_i(match), .endframe_i(endframe), .overflow_i(overflow),
		.irq_rx_o(irq_rx_o), .promisc_o(promisc), .macaddr_o(macaddr),
		.rx_valid_o(rx_valid), .rx_adr_o(rx_adr)
	);

	minimac_rx_assemble i_rx_assemble (
		.sys_clk_i(sys_clk_i), .reset_i(reset_i),
		.phy_rx_data_i(phy_rx_data_i), .phy_dv_i(phy_dv_i), .phy_rx_er_i(phy_rx_er_i),
		.byte_o(rx_byte), .byte_valid_o(byte_valid),
		.sof_o(sof), .eof_o(eof), .err_o(err)
	);

	minimac_rx_filter i_rx_filter (
		.sys_clk_i(sys_clk_i), .reset_i(reset_i),
		.byte_i(rx_byte), .byte_valid_i(byte_valid), .sof_i(sof), .eof_i(eof),
		.macaddr_i(macaddr), .promisc_i(promisc), .match_o(match)
	);

	minimac_rx_pack i_rx_pack (
		.sys_clk_i(sys_clk_i), .reset_i(reset_i),
		.byte_i(rx_byte), .byte_valid_i(byte_valid), .sof_i(sof), .eof_i(eof),
		.word_o(rx_word), .word_valid_o(word_valid), .last_o(last)
	);

	minimac_rx_dma #(.fifo_depth(fifo_depth)) i_rx_dma (
		.sys_clk_i(sys_clk_i), .reset_i(reset_i),
		.word_i(rx_word), .word_valid_i(word_valid), .last_i(last), .sof_i(sof),
		.rx_valid_i(rx_valid), .rx_adr_i(rx_adr), .wbm_ack_i(wbm_ack_i),
		.wbm_adr_o(wbm_adr_o), .wbm_dat_o(wbm_dat_o), .wbm_sel_o(wbm_sel_o),
		.wbm_we_o(wbm_we_o), .wbm_cyc_o(wbm_cyc_o), .wbm_stb_o(wbm_stb_o),
		.endframe_o(endframe), .overflow_o(overflow)
	);

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
// Testbench clock and reset
// 20 ns system clock, reset held high for the first 3 cycles

`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o; // 50 MHz
	end

	initial begin
		reset_o = 1'b1;
		repeat (3) @(posedge clk_o);
		#1 reset_o = 1'b0; // Released off the edge like all stimulus
	end

endmodule

`default_nettype wire

/* tb/tb_minimac.sv */
// minimac testbench
// Wishbone memory model with random ack delay, MII frame driver,
// CSR access tasks and directed receive tests

`timescale 1ns/10ps
`default_nettype none

module tb_minimac import minimac_pkg::*; ();

	localparam logic [3:0] bank      = 4'h3;              // CSR bank select
	localparam int         mem_words = 256;
	localparam mac_addr_t  station   = 48'h02_1a_2b_3c_4d_5e;
	localparam mac_addr_t  foreign   = 48'h02_99_88_77_66_55;
	localparam mac_addr_t  broadcast = 48'hff_ff_ff_ff_ff_ff;

	wire         clk;
	wire         reset;
	csr_adr_t    csr_adr;
	logic        csr_we;
	csr_data_t   csr_dat_w;  // Towards the DUT
	csr_data_t   csr_dat_r;  // Registered read data
	wire         irq_rx;
	word_adr_t   wbm_adr;
	word_t       wbm_dat;
	wire [3:0]   wbm_sel;
	wire         wbm_we;
	wire         wbm_cyc;
	wire         wbm_stb;
	logic        wbm_ack;
	nibble_t     phy_data;
	logic        phy_dv;
	logic        phy_er;

	word_t       mem [mem_words];
	int unsigned ack_delay [64]; // Drawn once after seeding
	int          delay_idx;
	int unsigned wait_left;
	logic        busy;           // Slave is inside a bus cycle
	int          bus_writes;
	byte_t       frame_buf [64]; // Frame under test, byte 0 first on the wire

	tb_clock i_tb_clock (.clk_o(clk), .reset_o(reset));

	minimac #(.csr_addr(bank), .fifo_depth(4)) i_minimac (
		.sys_clk_i(clk), .reset_i(reset),
		.csr_adr_i(csr_adr), .csr_we_i(csr_we), .csr_dat_i(csr_dat_w), .csr_dat_o(csr_dat_r),
		.irq_rx_o(irq_rx),
		.wbm_adr_o(wbm_adr), .wbm_dat_o(wbm_dat), .wbm_sel_o(wbm_sel), .wbm_we_o(wbm_we),
		.wbm_cyc_o(wbm_cyc), .wbm_stb_o(wbm_stb), .wbm_ack_i(wbm_ack),
		.phy_rx_data_i(phy_data), .phy_dv_i(phy_dv), .phy_rx_er_i(phy_er)
	);

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			stop_on_error($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_csr(input string name, input csr_data_t got, input csr_data_t exp);
		if (got !== exp)
			stop_on_error($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_count(input string name, input byte_count_t got,
			input byte_count_t exp);
		if (got !== exp)
			stop_on_error($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_state(input string name, input rx_state_e got, input rx_state_e exp);
		if (got !== exp)
			stop_on_error($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// Memory background, unique per word address
	function automatic word_t fill_value(input int adr);
		return 32'hc0de_0000 | word_t'(adr);
	endfunction

	task automatic fill_memory();
		int i;
		for (i = 0; i < mem_words; i++)
			mem[i] = fill_value(i);
	endtask

	// Wishbone slave, samples 1 ns after the edge and acks after 0 to 3 wait cycles
	always @(posedge clk) begin
		#1;
		if (wbm_stb !== wbm_cyc)
			stop_on_error("wbm_stb_o and wbm_cyc_o are not raised and dropped together");
		if (wbm_ack) begin
			wbm_ack = 1'b0; // Master took the ack at this edge
		end else if (wbm_cyc && wbm_stb) begin
			if (!busy) begin
				busy = 1'b1;
				wait_left = ack_delay[delay_idx];
				delay_idx = (delay_idx + 1) % 64;
			end
			if (wait_left == 0) begin
				if (!wbm_we || wbm_sel != 4'hf)
					stop_on_error("bus cycle without write enable or full byte select");
				if (wbm_adr >= mem_words)
					stop_on_error("bus write outside the memory model");
				mem[wbm_adr] = wbm_dat;
				bus_writes++;
				wbm_ack = 1'b1;
				busy = 1'b0;
			end else begin
				wait_left--;
			end
		end
	end

	task automatic csr_write(input logic [2:0] idx, input csr_data_t data);
		@(posedge clk);
		#1;
		csr_adr = {bank, 7'd0, idx};
		csr_dat_w = data;
		csr_we = 1'b1;
		@(posedge clk); // Register takes the value here
		#1;
		csr_we = 1'b0;
	endtask

	task automatic csr_read(input logic [2:0] idx, output csr_data_t data);
		@(posedge clk);
		#1;
		csr_adr = {bank, 7'd0, idx};
		csr_we = 1'b0;
		@(posedge clk);
		#1;
		data = csr_dat_r; // One cycle after the address
	endtask

	task automatic drive_nibble(input nibble_t n, input logic er);
		phy_data = n;
		phy_dv = 1'b1;
		phy_er = er;
		@(posedge clk);
		#1;
	endtask

	// Preamble, SFD, then each byte low nibble first; er_at < 0 means no rx_er
	task automatic send_frame(input int len, input int er_at);
		int i;
		@(posedge clk);
		#1;
		for (i = 0; i < 7; i++)
			drive_nibble(4'h5, 1'b0);
		drive_nibble(4'hd, 1'b0);
		for (i = 0; i < len; i++) begin
			drive_nibble(frame_buf[i][3:0], i == er_at);
			drive_nibble(frame_buf[i][7:4], i == er_at);
		end
		phy_dv = 1'b0;
		phy_er = 1'b0;
		phy_data = 4'h0;
	endtask

	// Destination MSB first, random payload
	task automatic build_frame(input mac_addr_t dst, input int len);
		int i;
		for (i = 0; i < len; i++)
			frame_buf[i] = (i < 6) ? dst[47 - 8 * i -: 8] : byte_t'($urandom);
	endtask

	task automatic wait_irq(input int max_cycles);
		int n;
		n = 0;
		while (irq_rx !== 1'b1 && n < max_cycles) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (irq_rx !== 1'b1)
			stop_on_error("timeout waiting for the rx interrupt");
	endtask

	// Fixed window in which irq_rx_o must stay low
	task automatic watch_no_irq(input int cycles);
		int n;
		for (n = 0; n < cycles; n++) begin
			@(posedge clk);
			#1;
			if (irq_rx !== 1'b0)
				stop_on_error("rx interrupt raised for a frame that should be dropped");
		end
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (reset !== 1'b0 && n < 20) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (reset !== 1'b0)
			stop_on_error("reset was never released");
	endtask

	task automatic set_station(input mac_addr_t mac);
		csr_write(REG_MAC_HI, {16'd0, mac[47:32]});
		csr_write(REG_MAC_LO, mac[31:0]);
	endtask

	task automatic arm_slot(input int base);
		fill_memory();
		csr_write(REG_RX_ADR, csr_data_t'(base));
		csr_write(REG_RX_STATE, 32'd1);
	endtask

	task automatic release_slot();
		csr_write(REG_RX_STATE, 32'd0);
	endtask

	task automatic expect_state(input rx_state_e exp);
		csr_data_t d;
		csr_read(REG_RX_STATE, d);
		check_state("REG_RX_STATE", rx_state_e'(d[1:0]), exp);
	endtask

	// Accepted frame: count, slot state and big-endian words from base
	task automatic expect_frame(input int base, input int len);
		csr_data_t d;
		int        k;
		int        b;
		byte_t     bv;
		word_t     exp;
		wait_irq(400);
		csr_read(REG_RX_COUNT, d);
		check_count("REG_RX_COUNT", byte_count_t'(d[10:0]), byte_count_t'(len));
		expect_state(RX_PENDING);
		for (k = 0; k < (len + 3) / 4; k++) begin
			exp = '0;
			for (b = 0; b < 4; b++) begin
				bv = (4 * k + b < len) ? frame_buf[4 * k + b] : 8'h00; // Zero pad
				exp = {exp[23:0], bv};
			end
			check_word($sformatf("mem[0x%h]", base + k), mem[base + k], exp);
		end
		// Word after the frame untouched
		check_word($sformatf("mem[0x%h]", base + k), mem[base + k], fill_value(base + k));
	endtask

	task automatic test_reset_and_registers();
		csr_data_t d;
		csr_data_t v;
		expect_state(RX_EMPTY);
		check_bit("irq_rx_o", irq_rx, 1'b0);
		check_bit("wbm_cyc_o", wbm_cyc, 1'b0);
		check_bit("wbm_stb_o", wbm_stb, 1'b0);
		csr_read(REG_SETUP, d);
		check_csr("REG_SETUP", d, 32'd0);
		v = $urandom;
		csr_write(REG_MAC_HI, v);
		csr_read(REG_MAC_HI, d);
		check_csr("REG_MAC_HI", d, {16'd0, v[15:0]}); // Upper 16 address bits only
		v = $urandom;
		csr_write(REG_MAC_LO, v);
		csr_read(REG_MAC_LO, d);
		check_csr("REG_MAC_LO", d, v);
		v = $urandom;
		csr_write(REG_RX_ADR, v);
		csr_read(REG_RX_ADR, d);
		check_csr("REG_RX_ADR", d, {2'd0, v[29:0]}); // 30-bit word address
	endtask

	task automatic test_station_frame();
		set_station(station);
		arm_slot(16);
		build_frame(station, 23);
		send_frame(23, -1);
		expect_frame(16, 23); // Sixth word carries 3 bytes
		release_slot();
	endtask

	task automatic test_broadcast_frame();
		arm_slot(64);
		build_frame(broadcast, 17);
		send_frame(17, -1);
		expect_frame(64, 17);
		release_slot();
		check_bit("irq_rx_o", irq_rx, 1'b0);
		expect_state(RX_EMPTY);
	endtask

	task automatic test_foreign_and_promisc();
		arm_slot(100);
		build_frame(foreign, 20);
		send_frame(20, -1);
		watch_no_irq(300);
		expect_state(RX_LOADED);
		csr_write(REG_SETUP, 32'd1); // Promiscuous
		fill_memory();
		send_frame(20, -1);
		expect_frame(100, 20); // Ends on a word boundary
		release_slot();
		csr_write(REG_SETUP, 32'd0);
	endtask

	task automatic test_rx_error();
		arm_slot(140);
		build_frame(station, 23);
		send_frame(23, 9); // rx_er on byte 9
		watch_no_irq(300);
		expect_state(RX_LOADED);
	endtask

	task automatic test_unarmed_slot();
		int writes_before;
		release_slot();
		expect_state(RX_EMPTY);
		writes_before = bus_writes;
		build_frame(station, 23);
		send_frame(23, -1);
		watch_no_irq(300);
		if (bus_writes != writes_before)
			stop_on_error("bus write seen while the slot was empty");
		arm_slot(200);
		build_frame(station, 31);
		send_frame(31, -1);
		expect_frame(200, 31);
		release_slot();
	endtask

	initial begin
		int i;
		int seed_draw;
		seed_draw = $urandom(8);
		for (i = 0; i < 64; i++)
			ack_delay[i] = $urandom % 4;
		csr_adr = '0;
		csr_we = 1'b0;
		csr_dat_w = '0;
		wbm_ack = 1'b0;
		phy_data = 4'h0;
		phy_dv = 1'b0;
		phy_er = 1'b0;
		busy = 1'b0;
		wait_left = 0;
		delay_idx = 0;
		bus_writes = 0;
		fill_memory();
		wait_reset();
		test_reset_and_registers();
		test_station_frame();
		test_broadcast_frame();
		test_foreign_and_promisc();
		test_rx_error();
		test_unarmed_slot();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
src/minimac_pkg.sv
src/minimac_ctlif.sv
src/minimac_rx_assemble.sv
src/minimac_rx_filter.sv
src/minimac_rx_pack.sv
src/minimac_rx_dma.sv
src/minimac.sv
tb/tb_clock.sv
tb/tb_minimac.sv
